// ==== sb_header_encoder.f ====
rtl/sb_hdr_pkg.sv
rtl/sb_field_encoder.sv
rtl/sb_hdr_fifo.sv
rtl/sb_hdr_packer.sv
rtl/sb_header_encoder.sv
bench/sb_header_encoder_asserts.sv
bench/tb_sb_header_encoder.sv

// ==== bench/tb_sb_header_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sb_header_encoder
	import sb_hdr_pkg::*;
();

	localparam int NUM_RANDOM      = 200;
	localparam int NUM_MSGS        = 13 + 12 + 36 + 12 + NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = NUM_MSGS * 20 + 200;
	localparam int DRAIN_CYCLES    = 50;

	typedef struct packed {
		logic        rdi;
		ltsm_state_t state;
		msg_no_t     no;
		logic [2:0]  info;
		logic        data;
		logic        test;
		sweep_test_t ttype;
		rdi_code_t   rcode;
		logic [3:0]  rsub;
		logic [1:0]  rinfo;
	} msg_t;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_msg_valid;
	logic        o_msg_ready;
	logic        i_header_ready;
	logic        o_header_valid;
	header_t     o_header;
	msg_t        cur_msg;
	logic        stall_en;
	header_t     exp_q [$];
	header_t     exp_hdr;
	subcode_t    ref_cnt = 8'h00;
	subcode_t    mon_base;
	ltsm_state_t ref_last = RESET;
	int          test_errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	sb_header_encoder i_dut (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_msg_valid    (i_msg_valid),
		.o_msg_ready    (o_msg_ready),
		.i_rdi_msg      (cur_msg.rdi),
		.i_state        (cur_msg.state),
		.i_msg_no       (cur_msg.no),
		.i_msg_info     (cur_msg.info),
		.i_data_valid   (cur_msg.data),
		.i_test_en      (cur_msg.test),
		.i_test_type    (cur_msg.ttype),
		.i_rdi_code     (cur_msg.rcode),
		.i_rdi_sub_code (cur_msg.rsub),
		.i_rdi_info     (cur_msg.rinfo),
		.o_header       (o_header),
		.o_header_valid (o_header_valid),
		.i_header_ready (i_header_ready)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic subcode_t counter_start(input msg_t m, input subcode_t cnt,
			input ltsm_state_t last);
		if ((m.state != last) || ((m.state == SBINIT) && (m.no == 4'd3))) begin
			return 8'h00;
		end
		return cnt;
	endfunction

	// One subcode byte per message pair 1-2 .. 9
	function automatic subcode_t sweep_subcode(input sweep_test_t t, input msg_no_t n);
		logic [39:0] row;
		int          pair;
		if ((n == 4'd0) || (n > 4'd9)) begin
			return 8'h00;
		end
		pair = (int'(n) + 1) / 2;
		case (t)
			TX_POINT: row = 40'h01_02_03_04_00;
			TX_SWEEP: row = 40'h05_02_06_00_00;
			RX_POINT: row = 40'h07_02_08_09_00;
			default:  row = 40'h0A_02_0B_0D_0C;
		endcase
		return row[(5 - pair) * 8 +: 8];
	endfunction

	function automatic header_t expected_header(input msg_t m, input subcode_t cnt_base);
		opcode_t   op;
		msg_code_t code;
		subcode_t  sub;
		msg_info_t info;
		header_t   h;
		if (m.rdi) begin
			op   = OPC_NO_DATA;
			code = msg_code_t'(m.rcode);
			sub  = subcode_t'(m.rsub);
			if (m.rcode == RDI_NOP) begin
				info = msg_info_t'(m.rinfo) + 16'd1;
			end else if (m.rcode == RDI_RESP) begin
				info = m.rinfo[0] ? 16'hFFFF : 16'h0000;
			end else begin
				info = 16'h0000;
			end
		end else begin
			op   = m.data ? OPC_WITH_DATA : OPC_NO_DATA;
			info = msg_info_t'(m.info);
			code[3:0] = m.no[0] ? 4'h5 : 4'hA;
			if (m.test) begin
				code[7:4] = 4'h8;
				if (m.no == 4'd9) begin
					code[3:0] = 4'h1;
				end
				sub = sweep_subcode(m.ttype, m.no);
				if (((m.ttype == TX_POINT) || (m.ttype == RX_SWEEP)) && (m.no == 4'd6)) begin
					info = msg_info_t'(m.info[1:0]) << 4;
				end
			end else begin
				case (m.state)
					SBINIT:        code[7:4] = 4'h9;
					MBINIT:        code[7:4] = 4'hA;
					MBTRAIN:       code[7:4] = 4'hB;
					PHYRETRAIN:    code[7:4] = 4'hC;
					TRAINERROR_HS: code[7:4] = 4'hE;
					default:       code[7:4] = 4'h0;
				endcase
				if ((m.state == SBINIT) && (m.no == 4'd3)) begin
					code[3:0] = 4'h1;
				end
				sub = cnt_base;
			end
		end
		h        = '0;
		h[4:0]   = op;
		h[21:14] = code;
		h[31:29] = 3'd2;
		h[39:32] = sub;
		h[55:40] = info;
		h[58:56] = 3'd6;
		return h;
	endfunction

	// Message builders
	function automatic msg_t training_msg(input ltsm_state_t s, input msg_no_t n,
			input logic d, input logic [2:0] info);
		msg_t m;
		m       = '0;
		m.state = s;
		m.no    = n;
		m.data  = d;
		m.info  = info;
		return m;
	endfunction

	function automatic msg_t sweep_msg(input sweep_test_t t, input msg_no_t n,
			input logic [2:0] info);
		msg_t m;
		m       = '0;
		m.test  = 1'b1;
		m.ttype = t;
		m.no    = n;
		m.info  = info;
		return m;
	endfunction

	function automatic msg_t rdi_msg(input rdi_code_t c, input logic [3:0] sub,
			input logic [1:0] info);
		msg_t m;
		m       = '0;
		m.rdi   = 1'b1;
		m.rcode = c;
		m.rsub  = sub;
		m.rinfo = info;
		return m;
	endfunction

	// ----------------------------------------
	// Monitor and scoreboard
	// ----------------------------------------
	always @(posedge i_clk) begin
		if (i_rst_n && i_msg_valid && o_msg_ready) begin
			mon_base = counter_start(cur_msg, ref_cnt, ref_last);
			exp_q.push_back(expected_header(cur_msg, mon_base));
			if (!cur_msg.rdi && !cur_msg.test) begin
				ref_last = cur_msg.state;
				ref_cnt  = cur_msg.no[0] ? mon_base : mon_base + 8'd1;
			end
		end
	end

	always @(posedge i_clk) begin
		if (i_rst_n && o_header_valid && i_header_ready) begin
			assert (exp_q.size() != 0) else begin
				$display("Error at %0t: header %h arrived with none expected", $time, o_header);
				test_errors++;
			end
			if (exp_q.size() != 0) begin
				exp_hdr = exp_q.pop_front();
				assert (o_header === exp_hdr) else begin
					$display("MISMATCH at %0t: o_header expected %h actual %h",
						$time, exp_hdr, o_header);
					test_errors++;
				end
			end
		end
	end

	// Sink stalls at random while enabled
	task automatic drive_sink_ready();
		forever begin
			@(posedge i_clk);
			#1;
			i_header_ready = stall_en ? 1'($urandom_range(0, 1)) : 1'b1;
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("Timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	// ----------------------------------------
	// Stimulus tasks
	// ----------------------------------------
	task automatic send_msg(input msg_t m);
		cur_msg     = m;
		i_msg_valid = 1'b1;
		@(posedge i_clk);
		while (!o_msg_ready) begin
			@(posedge i_clk);
		end
		#1;
		i_msg_valid = 1'b0;
	endtask

	task automatic close_test(input string name);
		int waited;
		waited = 0;
		while ((exp_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
			@(posedge i_clk);
			#1;
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			$display("Error: %0d expected headers never came out in %s", exp_q.size(), name);
			test_errors++;
			exp_q.delete();
		end
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		ltsm_state_t states [6];
		msg_t        m;
		cur_msg        = '0;
		i_msg_valid    = 1'b0;
		i_header_ready = 1'b1;
		i_rst_n        = 1'b0;
		stall_en       = 1'b0;
		void'($urandom(7652));
		fork
			drive_sink_ready();
		join_none
		states = '{SBINIT, MBINIT, MBTRAIN, PHYRETRAIN, TRAINERROR_HS, ACTIVE};
		repeat (10) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;

		// Codes per state, both opcodes, out-of-reset message
		foreach (states[i]) begin
			send_msg(training_msg(states[i], 4'd1, 1'b0, 3'd5));
			send_msg(training_msg(states[i], 4'd2, 1'b1, 3'd2));
		end
		send_msg(training_msg(SBINIT, 4'd3, 1'b0, 3'd0));
		close_test("training codes");

		// Counter with test and RDI traffic in between
		send_msg(training_msg(SBINIT, 4'd1, 1'b0, 3'd1));
		send_msg(training_msg(SBINIT, 4'd2, 1'b0, 3'd1));
		send_msg(training_msg(SBINIT, 4'd1, 1'b0, 3'd2));
		send_msg(sweep_msg(RX_POINT, 4'd4, 3'd3));
		send_msg(training_msg(SBINIT, 4'd2, 1'b0, 3'd2));
		send_msg(training_msg(SBINIT, 4'd3, 1'b0, 3'd0));
		send_msg(training_msg(SBINIT, 4'd4, 1'b0, 3'd0));
		send_msg(training_msg(MBINIT, 4'd1, 1'b1, 3'd4));
		send_msg(training_msg(MBINIT, 4'd2, 1'b1, 3'd4));
		send_msg(rdi_msg(RDI_REQ, 4'd7, 2'd1));
		send_msg(training_msg(MBINIT, 4'd4, 1'b0, 3'd6));
		send_msg(training_msg(MBTRAIN, 4'd2, 1'b0, 3'd7));
		close_test("subcode counter");

		for (int t = 0; t < 4; t++) begin
			for (int n = 1; n <= 9; n++) begin
				send_msg(sweep_msg(sweep_test_t'(t), msg_no_t'(n), 3'(n + t)));
			end
		end
		close_test("point and sweep tests");

		for (int c = 0; c < 3; c++) begin
			for (int v = 0; v < 4; v++) begin
				send_msg(rdi_msg(rdi_code_t'(c), 4'(c * 4 + v), 2'(v)));
			end
		end
		close_test("rdi messages");

		stall_en = 1'b1;
		repeat (NUM_RANDOM) begin
			m       = '0;
			m.rdi   = ($urandom_range(0, 3) == 0);
			m.state = ltsm_state_t'($urandom_range(0, 11));
			m.no    = msg_no_t'($urandom_range(1, 9));
			m.info  = 3'($urandom);
			m.data  = 1'($urandom);
			m.test  = ($urandom_range(0, 3) == 0);
			m.ttype = sweep_test_t'($urandom_range(0, 3));
			m.rcode = rdi_code_t'($urandom_range(0, 2));
			m.rsub  = 4'($urandom);
			m.rinfo = 2'($urandom);
			send_msg(m);
		end
		stall_en = 1'b0;
		close_test("random with back-pressure");

		assert (i_dut.u_asserts.fail_count == 0) else begin
			$display("Error: handshake assertions failed %0d times", i_dut.u_asserts.fail_count);
			tests_failed++;
		end
		$display("Tests ok: %0d, tests with errors: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/sb_header_encoder_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module sb_header_encoder_asserts
	import sb_hdr_pkg::*;
(
	input wire          i_clk,
	input wire          i_rst_n,
	input wire          i_msg_valid,
	input wire          o_msg_ready,
	input wire header_t o_header,
	input wire          o_header_valid,
	input wire          i_header_ready
);

	int   fail_count = 0;
	logic first_seen;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			first_seen <= 1'b0;
		end else if (i_msg_valid && o_msg_ready) begin
			first_seen <= 1'b1;
		end
	end

	// ----------------------------------------
	// Handshake properties
	// ----------------------------------------
	reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !o_header_valid)
		else begin
			$error("o_header_valid high during reset");
			fail_count++;
		end

	// Stalled header must not move
	stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_header_valid && !i_header_ready) |=> (o_header_valid && $stable(o_header)))
		else begin
			$error("o_header changed or dropped while stalled");
			fail_count++;
		end

	ready_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!first_seen |-> o_msg_ready)
		else begin
			$error("o_msg_ready low before any message");
			fail_count++;
		end

endmodule

bind sb_header_encoder sb_header_encoder_asserts u_asserts (
	.i_clk          (i_clk),
	.i_rst_n        (i_rst_n),
	.i_msg_valid    (i_msg_valid),
	.o_msg_ready    (o_msg_ready),
	.o_header       (o_header),
	.o_header_valid (o_header_valid),
	.i_header_ready (i_header_ready)
);

`default_nettype wire

// ==== rtl/sb_header_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module sb_header_encoder
	import sb_hdr_pkg::*;
(
	input  wire              i_clk,
	input  wire              i_rst_n,
	// Message input
	input  wire              i_msg_valid,
	output logic             o_msg_ready,
	input  wire              i_rdi_msg,
	input  wire ltsm_state_t i_state,
	input  wire msg_no_t     i_msg_no,
	input  wire [2:0]        i_msg_info,
	input  wire              i_data_valid,
	input  wire              i_test_en,
	input  wire sweep_test_t i_test_type,
	input  wire rdi_code_t   i_rdi_code,
	input  wire [3:0]        i_rdi_sub_code,
	input  wire [1:0]        i_rdi_info,
	// Header output
	output header_t          o_header,
	output logic             o_header_valid,
	input  wire              i_header_ready
);

	// ----------------------------------------
	// Encoder to FIFO
	// ----------------------------------------
	logic      enc_valid;
	opcode_t   enc_opcode;
	msg_code_t enc_msg_code;
	subcode_t  enc_subcode;
	msg_info_t enc_info;
	logic      fifo_ready;

	// FIFO to packer
	logic      fifo_valid;
	opcode_t   fifo_opcode;
	msg_code_t fifo_msg_code;
	subcode_t  fifo_subcode;
	msg_info_t fifo_info;
	logic      pack_ready;

	sb_field_encoder u_encoder (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_msg_valid    (i_msg_valid),
		.o_msg_ready    (o_msg_ready),
		.i_rdi_msg      (i_rdi_msg),
		.i_state        (i_state),
		.i_msg_no       (i_msg_no),
		.i_msg_info     (i_msg_info),
		.i_data_valid   (i_data_valid),
		.i_test_en      (i_test_en),
		.i_test_type    (i_test_type),
		.i_rdi_code     (i_rdi_code),
		.i_rdi_sub_code (i_rdi_sub_code),
		.i_rdi_info     (i_rdi_info),
		.o_valid        (enc_valid),
		.o_opcode       (enc_opcode),
		.o_msg_code     (enc_msg_code),
		.o_subcode      (enc_subcode),
		.o_info         (enc_info),
		.i_ready        (fifo_ready)
	);

	sb_hdr_fifo u_fifo (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_valid    (enc_valid),
		.o_ready    (fifo_ready),
		.i_opcode   (enc_opcode),
		.i_msg_code (enc_msg_code),
		.i_subcode  (enc_subcode),
		.i_info     (enc_info),
		.o_valid    (fifo_valid),
		.i_ready    (pack_ready),
		.o_opcode   (fifo_opcode),
		.o_msg_code (fifo_msg_code),
		.o_subcode  (fifo_subcode),
		.o_info     (fifo_info)
	);

	sb_hdr_packer u_packer (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_valid        (fifo_valid),
		.o_ready        (pack_ready),
		.i_opcode       (fifo_opcode),
		.i_msg_code     (fifo_msg_code),
		.i_subcode      (fifo_subcode),
		.i_info         (fifo_info),
		.o_header       (o_header),
		.o_header_valid (o_header_valid),
		.i_header_ready (i_header_ready)
	);

endmodule

`default_nettype wire

// ==== rtl/sb_hdr_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sb_hdr_packer
	import sb_hdr_pkg::*;
(
	input  wire            i_clk,
	input  wire            i_rst_n,
	// From FIFO head
	input  wire            i_valid,
	output logic           o_ready,
	input  wire opcode_t   i_opcode,
	input  wire msg_code_t i_msg_code,
	input  wire subcode_t  i_subcode,
	input  wire msg_info_t i_info,
	// To sink
	output header_t        o_header,
	output logic           o_header_valid,
	input  wire            i_header_ready
);

	header_t hdr_d;
	logic    load;

	// Output register frees up when empty or being taken
	assign o_ready = !o_header_valid || i_header_ready;
	assign load    = i_valid && o_ready;

	// ----------------------------------------
	// Header assembly
	// ----------------------------------------
	always_comb begin
		hdr_d                      = '0;
		hdr_d[OPC_MSB:OPC_LSB]     = i_opcode;
		hdr_d[CODE_MSB:CODE_LSB]   = i_msg_code;
		hdr_d[SRCID_MSB:SRCID_LSB] = SRCID;
		hdr_d[SUB_MSB:SUB_LSB]     = i_subcode;
		hdr_d[INFO_MSB:INFO_LSB]   = i_info;
		hdr_d[DSTID_MSB:DSTID_LSB] = DSTID;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_header_valid <= 1'b0;
		end else if (load) begin
			o_header_valid <= 1'b1;
		end else if (i_header_ready) begin
			o_header_valid <= 1'b0;
		end
	end

	// Held while the sink stalls
	always_ff @(posedge i_clk) begin
		if (load) begin
			o_header <= hdr_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sb_hdr_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sb_hdr_fifo
	import sb_hdr_pkg::*;
(
	input  wire            i_clk,
	input  wire            i_rst_n,
	// Write side
	input  wire            i_valid,
	output logic           o_ready,
	input  wire opcode_t   i_opcode,
	input  wire msg_code_t i_msg_code,
	input  wire subcode_t  i_subcode,
	input  wire msg_info_t i_info,
	// Read side
	output logic           o_valid,
	input  wire            i_ready,
	output opcode_t        o_opcode,
	output msg_code_t      o_msg_code,
	output subcode_t       o_subcode,
	output msg_info_t      o_info
);

	localparam fifo_ptr_t LAST_PTR = fifo_ptr_t'(FIFO_DEPTH - 1);
	localparam fifo_cnt_t FULL_CNT = fifo_cnt_t'(FIFO_DEPTH);

	opcode_t   opcode_mem   [FIFO_DEPTH];
	msg_code_t msg_code_mem [FIFO_DEPTH];
	subcode_t  subcode_mem  [FIFO_DEPTH];
	msg_info_t info_mem     [FIFO_DEPTH];

	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_cnt_t count;
	logic      wr_en;
	logic      rd_en;

	assign o_ready = (count != FULL_CNT);
	assign o_valid = (count != '0);
	assign wr_en   = i_valid && o_ready;
	assign rd_en   = o_valid && i_ready;

	// Head entry straight from storage
	assign o_opcode   = opcode_mem[rd_ptr];
	assign o_msg_code = msg_code_mem[rd_ptr];
	assign o_subcode  = subcode_mem[rd_ptr];
	assign o_info     = info_mem[rd_ptr];

	// ----------------------------------------
	// Pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop keeps the count
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			opcode_mem[wr_ptr]   <= i_opcode;
			msg_code_mem[wr_ptr] <= i_msg_code;
			subcode_mem[wr_ptr]  <= i_subcode;
			info_mem[wr_ptr]     <= i_info;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sb_field_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module sb_field_encoder
	import sb_hdr_pkg::*;
(
	input  wire              i_clk,
	input  wire              i_rst_n,
	input  wire              i_msg_valid,
	output logic             o_msg_ready,
	input  wire              i_rdi_msg,
	input  wire ltsm_state_t i_state,
	input  wire msg_no_t     i_msg_no,
	input  wire [2:0]        i_msg_info,
	input  wire              i_data_valid,
	input  wire              i_test_en,
	input  wire sweep_test_t i_test_type,
	input  wire rdi_code_t   i_rdi_code,
	input  wire [3:0]        i_rdi_sub_code,
	input  wire [1:0]        i_rdi_info,
	output logic             o_valid,
	output opcode_t          o_opcode,
	output msg_code_t        o_msg_code,
	output subcode_t         o_subcode,
	output msg_info_t        o_info,
	input  wire              i_ready
);

	// Upper nibble of the message code for a training state
	function automatic logic [3:0] state_hi(input ltsm_state_t s);
		case (s)
			SBINIT:        return HI_SBINIT;
			MBINIT:        return HI_MBINIT;
			MBTRAIN:       return HI_MBTRAIN;
			PHYRETRAIN:    return HI_PHYRETRAIN;
			TRAINERROR_HS: return HI_TRAINERROR_HS;
			default:       return HI_OTHER;
		endcase
	endfunction

	// Point/sweep subcode, looked up by message pair
	function automatic subcode_t test_subcode(input sweep_test_t t, input msg_no_t n);
		logic [2:0] pair;
		case (n)
			4'd1, 4'd2: pair = 3'd1;
			4'd3, 4'd4: pair = 3'd2;
			4'd5, 4'd6: pair = 3'd3;
			4'd7, 4'd8: pair = 3'd4;
			4'd9:       pair = 3'd5;
			default:    pair = 3'd0;
		endcase
		case ({t, pair})
			{TX_POINT, 3'd1}: return 8'h01;
			{TX_POINT, 3'd2}: return 8'h02;
			{TX_POINT, 3'd3}: return 8'h03;
			{TX_POINT, 3'd4}: return 8'h04;
			{TX_SWEEP, 3'd1}: return 8'h05;
			{TX_SWEEP, 3'd2}: return 8'h02;
			{TX_SWEEP, 3'd3}: return 8'h06;
			{RX_POINT, 3'd1}: return 8'h07;
			{RX_POINT, 3'd2}: return 8'h02;
			{RX_POINT, 3'd3}: return 8'h08;
			{RX_POINT, 3'd4}: return 8'h09;
			{RX_SWEEP, 3'd1}: return 8'h0A;
			{RX_SWEEP, 3'd2}: return 8'h02;
			{RX_SWEEP, 3'd3}: return 8'h0B;
			{RX_SWEEP, 3'd4}: return 8'h0D;
			{RX_SWEEP, 3'd5}: return 8'h0C;
			default:          return 8'h00;
		endcase
	endfunction

	logic        accept;
	logic        is_req;
	logic        out_of_reset;
	logic        normal_msg;
	logic        shifted_info;
	logic [3:0]  req_nibble;
	subcode_t    cnt_q;
	subcode_t    cnt_base;
	ltsm_state_t last_state_q;
	opcode_t     opcode_d;
	msg_code_t   msg_code_d;
	subcode_t    subcode_d;
	msg_info_t   info_d;

	// Stage is free when empty or drained this cycle
	assign o_msg_ready = !o_valid || i_ready;
	assign accept      = i_msg_valid && o_msg_ready;

	assign is_req       = i_msg_no[0];
	assign out_of_reset = (i_state == SBINIT) && (i_msg_no == 4'd3);
	assign normal_msg   = !i_rdi_msg && !i_test_en;
	assign shifted_info = ((i_test_type == TX_POINT) || (i_test_type == RX_SWEEP)) &&
	                      (i_msg_no == 4'd6);
	assign req_nibble   = is_req ? CODE_REQ : CODE_RESP;

	// Counter restarts on a new state or on the out-of-reset message
	assign cnt_base = ((i_state != last_state_q) || out_of_reset) ? 8'h00 : cnt_q;

	// ----------------------------------------
	// Field selection
	// ----------------------------------------
	always_comb begin
		if (i_rdi_msg) begin
			opcode_d   = OPC_NO_DATA;
			msg_code_d = {6'b0, i_rdi_code};
			subcode_d  = {4'b0, i_rdi_sub_code};
			case (i_rdi_code)
				RDI_NOP:  info_d = {14'b0, i_rdi_info} + 16'd1;
				RDI_RESP: info_d = {16{i_rdi_info[0]}};
				default:  info_d = 16'h0000;
			endcase
		end else begin
			opcode_d = i_data_valid ? OPC_WITH_DATA : OPC_NO_DATA;
			if (i_test_en) begin
				msg_code_d = {CODE_TEST_HI, (i_msg_no == 4'd9) ? CODE_SPECIAL : req_nibble};
				subcode_d  = test_subcode(i_test_type, i_msg_no);
				// Results field of the test response sits at bits 5..4
				info_d     = shifted_info ? {10'b0, i_msg_info[1:0], 4'b0} : {13'b0, i_msg_info};
			end else begin
				msg_code_d = {state_hi(i_state), out_of_reset ? CODE_SPECIAL : req_nibble};
				subcode_d  = cnt_base;
				info_d     = {13'b0, i_msg_info};
			end
		end
	end

	// ----------------------------------------
	// Subcode counter
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_q        <= 8'h00;
			last_state_q <= RESET;
		end else if (accept && normal_msg) begin
			last_state_q <= i_state;
			// Only a response moves the count on
			cnt_q        <= is_req ? cnt_base : cnt_base + 8'd1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else if (o_msg_ready) begin
			o_valid <= i_msg_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_opcode   <= opcode_d;
			o_msg_code <= msg_code_d;
			o_subcode  <= subcode_d;
			o_info     <= info_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sb_hdr_pkg.sv ====
`default_nettype none

package sb_hdr_pkg;

	// ----------------------------------------
	// Field types
	// ----------------------------------------
	typedef logic [4:0]  opcode_t;
	typedef logic [7:0]  msg_code_t;
	typedef logic [7:0]  subcode_t;
	typedef logic [15:0] msg_info_t;
	// Odd number is a request
	typedef logic [3:0]  msg_no_t;
	typedef logic [61:0] header_t;
	typedef logic [2:0]  node_id_t;

	// Link training states
	typedef enum logic [3:0] {
		RESET            = 4'd0,
		FINISH_RESET     = 4'd1,
		SBINIT           = 4'd2,
		MBINIT           = 4'd3,
		MBTRAIN          = 4'd4,
		LINKINIT         = 4'd5,
		ACTIVE           = 4'd6,
		TRAINERROR_HS    = 4'd7,
		TRAINERROR       = 4'd8,
		LINKMGMT_RETRAIN = 4'd9,
		PHYRETRAIN       = 4'd10,
		L1_L2            = 4'd11
	} ltsm_state_t;

	// Point and sweep test types
	typedef enum logic [1:0] {
		TX_POINT = 2'd0,
		TX_SWEEP = 2'd1,
		RX_POINT = 2'd2,
		RX_SWEEP = 2'd3
	} sweep_test_t;

	// RDI message codes
	typedef enum logic [1:0] {
		RDI_NOP  = 2'd0,
		RDI_REQ  = 2'd1,
		RDI_RESP = 2'd2
	} rdi_code_t;

	// ----------------------------------------
	// Opcodes and IDs
	// ----------------------------------------
	localparam opcode_t  OPC_NO_DATA   = 5'h12;
	localparam opcode_t  OPC_WITH_DATA = 5'h1B;
	localparam node_id_t SRCID         = 3'd2;
	localparam node_id_t DSTID         = 3'd6;

	// Message code nibbles
	localparam logic [3:0] CODE_REQ     = 4'h5;
	localparam logic [3:0] CODE_RESP    = 4'hA;
	localparam logic [3:0] CODE_SPECIAL = 4'h1;
	localparam logic [3:0] CODE_TEST_HI = 4'h8;

	// Upper nibble per training state
	localparam logic [3:0] HI_SBINIT        = 4'h9;
	localparam logic [3:0] HI_MBINIT        = 4'hA;
	localparam logic [3:0] HI_MBTRAIN       = 4'hB;
	localparam logic [3:0] HI_PHYRETRAIN    = 4'hC;
	localparam logic [3:0] HI_TRAINERROR_HS = 4'hE;
	localparam logic [3:0] HI_OTHER         = 4'h0;

	// ----------------------------------------
	// Header bit positions
	// ----------------------------------------
	localparam int OPC_LSB   = 0;
	localparam int OPC_MSB   = 4;
	localparam int CODE_LSB  = 14;
	localparam int CODE_MSB  = 21;
	localparam int SRCID_LSB = 29;
	localparam int SRCID_MSB = 31;
	localparam int SUB_LSB   = 32;
	localparam int SUB_MSB   = 39;
	localparam int INFO_LSB  = 40;
	localparam int INFO_MSB  = 55;
	localparam int DSTID_LSB = 56;
	localparam int DSTID_MSB = 58;

	// Header FIFO sizing
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
	typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

endpackage

`default_nettype wire
